// ==== logic/axis_beat_if.sv ====
`timescale 1ns/1ns

interface axis_beat_if;

    // head of the ingress FIFO
    logic                        valid;
    logic                        ready;
    axis_stream_pkg::axis_beat_t beat;

    // FIFO side
    modport source (
        output valid,
        output beat,
        input  ready
    );

    // router side
    modport sink (
        input  valid,
        input  beat,
        output ready
    );

endinterface

// ==== logic/axis_cfg_pkg.sv ====
`include "axis_switch_consts.svh"

package axis_cfg_pkg;

    ////////////////////////////////////////
    // register map types
    ////////////////////////////////////////

    // FIFO ready threshold, offset 0 bits 3:0
    typedef logic [3:0] th_t;

    // bus word seen either raw or as the threshold register
    typedef union packed {
        logic [`AXIS_DATA_W-1:0] raw;
        struct packed {
            logic [`AXIS_DATA_W-5:0] rsvd;
            th_t                     th;
        } f;
    } cfg_word_u;

endpackage

// ==== logic/axis_ingress_fifo.sv ====
`timescale 1ns/1ns
`include "axis_switch_consts.svh"

module axis_ingress_fifo (
    input  logic                        axis_clk,
    input  logic                        axi_reset_n,
    input  axis_stream_pkg::axis_beat_t in_beat,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  axis_cfg_pkg::th_t           threshold,
    axis_beat_if.source                 head
);

    localparam int DEPTH  = `AXIS_FIFO_DEPTH;
    localparam int ADDR_W = $clog2(DEPTH);

    axis_stream_pkg::axis_beat_t mem [DEPTH];

    // one extra bit tells full from empty
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;
    logic [ADDR_W:0] wr_ptr_nxt;
    logic [ADDR_W:0] rd_ptr_nxt;
    logic [ADDR_W:0] occ_nxt;
    logic            push;
    logic            pop;

    assign push = in_valid && in_ready;
    assign pop  = head.valid && head.ready;

    assign wr_ptr_nxt = push ? wr_ptr + 1'b1 : wr_ptr;
    assign rd_ptr_nxt = pop ? rd_ptr + 1'b1 : rd_ptr;
    assign occ_nxt    = wr_ptr_nxt - rd_ptr_nxt;

    // ready follows occupancy after the edge
    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            in_ready <= 1'b1;
        end else begin
            wr_ptr   <= wr_ptr_nxt;
            rd_ptr   <= rd_ptr_nxt;
            in_ready <= (occ_nxt <= (ADDR_W + 1)'(threshold));
        end
    end

    always_ff @(posedge axis_clk) begin
        if (push) begin
            mem[wr_ptr[ADDR_W-1:0]] <= in_beat;
        end
    end

    // head entry straight out of the array
    assign head.valid = (wr_ptr != rd_ptr);
    assign head.beat  = mem[rd_ptr[ADDR_W-1:0]];

endmodule

// ==== logic/axis_stream_pkg.sv ====
`include "axis_switch_consts.svh"

package axis_stream_pkg;

    ////////////////////////////////////////
    // stream beat
    ////////////////////////////////////////

    // one beat as it sits in the FIFO, 37 bits
    typedef struct packed {
        logic [`AXIS_DATA_W-1:0] data;
        logic                    last;
        logic [`AXIS_USER_W-1:0] user;
        logic [`AXIS_TID_W-1:0]  tid;
    } axis_beat_t;

    // upstream source number, 0 to 2
    typedef logic [1:0] src_idx_t;

endpackage

// ==== logic/axis_switch.sv ====
`timescale 1ns/1ns
`include "axis_switch_consts.svh"

module axis_switch (
    input  logic                        axis_clk,
    input  logic                        axi_reset_n,
    // configuration, AXI-Lite
    input  logic                        cc_as_enable,
    input  logic                        axi_awvalid,
    input  logic [`AXIS_CFG_ADDR_W-1:0] axi_awaddr,
    output logic                        axi_awready,
    input  logic                        axi_wvalid,
    input  logic [`AXIS_DATA_W-1:0]     axi_wdata,
    input  logic [`AXIS_DATA_W/8-1:0]   axi_wstrb,
    output logic                        axi_wready,
    input  logic                        axi_arvalid,
    input  logic [`AXIS_CFG_ADDR_W-1:0] axi_araddr,
    output logic                        axi_arready,
    output logic                        axi_rvalid,
    output logic [`AXIS_DATA_W-1:0]     axi_rdata,
    input  logic                        axi_rready,
    // user project source
    input  logic [`AXIS_DATA_W-1:0]     up_as_tdata,
    input  logic                        up_as_tlast,
    input  logic [`AXIS_USER_W-1:0]     up_as_tuser,
    input  logic                        up_as_tvalid,
    output logic                        as_up_tready,
    // axilite bridge source
    input  logic [`AXIS_DATA_W-1:0]     aa_as_tdata,
    input  logic                        aa_as_tlast,
    input  logic [`AXIS_USER_W-1:0]     aa_as_tuser,
    input  logic                        aa_as_tvalid,
    output logic                        as_aa_tready,
    // logic analyzer source
    input  logic [`AXIS_DATA_W-1:0]     la_as_tdata,
    input  logic                        la_as_tlast,
    input  logic [`AXIS_USER_W-1:0]     la_as_tuser,
    input  logic                        la_as_tvalid,
    output logic                        as_la_tready,
    // to serdes
    output logic [`AXIS_DATA_W-1:0]     as_is_tdata,
    output logic                        as_is_tlast,
    output logic [`AXIS_USER_W-1:0]     as_is_tuser,
    output logic [`AXIS_TID_W-1:0]      as_is_tid,
    output logic                        as_is_tvalid,
    input  logic                        is_as_tready,
    // from serdes
    input  logic [`AXIS_DATA_W-1:0]     is_as_tdata,
    input  logic                        is_as_tlast,
    input  logic [`AXIS_USER_W-1:0]     is_as_tuser,
    input  logic [`AXIS_TID_W-1:0]      is_as_tid,
    input  logic                        is_as_tvalid,
    output logic                        as_is_tready,
    // to user project
    output logic [`AXIS_DATA_W-1:0]     as_up_tdata,
    output logic                        as_up_tlast,
    output logic [`AXIS_USER_W-1:0]     as_up_tuser,
    output logic                        as_up_tvalid,
    input  logic                        up_as_tready,
    // to axilite bridge
    output logic [`AXIS_DATA_W-1:0]     as_aa_tdata,
    output logic                        as_aa_tlast,
    output logic [`AXIS_USER_W-1:0]     as_aa_tuser,
    output logic                        as_aa_tvalid,
    input  logic                        aa_as_tready
);

    axis_stream_pkg::axis_beat_t src_beat [3];
    axis_stream_pkg::axis_beat_t is_beat;
    axis_stream_pkg::axis_beat_t ser_beat;
    axis_stream_pkg::axis_beat_t up_beat;
    axis_stream_pkg::axis_beat_t aa_beat;
    axis_cfg_pkg::th_t           threshold;

    axis_beat_if fifo_head ();

    ////////////////////////////////////////
    // upstream, three sources to serdes
    ////////////////////////////////////////

    assign src_beat[0] = '{data: up_as_tdata, last: up_as_tlast, user: up_as_tuser,
                           tid: `AXIS_TID_W'(`AXIS_TID_UP)};
    assign src_beat[1] = '{data: aa_as_tdata, last: aa_as_tlast, user: aa_as_tuser,
                           tid: `AXIS_TID_W'(`AXIS_TID_AA)};
    assign src_beat[2] = '{data: la_as_tdata, last: la_as_tlast, user: la_as_tuser,
                           tid: `AXIS_TID_W'(`AXIS_TID_LA)};

    axis_upstream_arbiter u_arbiter (
        .axis_clk    (axis_clk),
        .axi_reset_n (axi_reset_n),
        .src_beat    (src_beat),
        .src_valid   ({la_as_tvalid, aa_as_tvalid, up_as_tvalid}),
        .src_ready   ({as_la_tready, as_aa_tready, as_up_tready}),
        .out_beat    (is_beat),
        .out_valid   (as_is_tvalid),
        .out_ready   (is_as_tready)
    );

    assign as_is_tdata = is_beat.data;
    assign as_is_tlast = is_beat.last;
    assign as_is_tuser = is_beat.user;
    assign as_is_tid   = is_beat.tid;

    ////////////////////////////////////////
    // downstream, serdes to up and aa
    ////////////////////////////////////////

    assign ser_beat = '{data: is_as_tdata, last: is_as_tlast, user: is_as_tuser,
                        tid: is_as_tid};

    axis_ingress_fifo u_fifo (
        .axis_clk    (axis_clk),
        .axi_reset_n (axi_reset_n),
        .in_beat     (ser_beat),
        .in_valid    (is_as_tvalid),
        .in_ready    (as_is_tready),
        .threshold   (threshold),
        .head        (fifo_head)
    );

    axis_tid_router u_router (
        .head     (fifo_head),
        .up_beat  (up_beat),
        .up_valid (as_up_tvalid),
        .up_ready (up_as_tready),
        .aa_beat  (aa_beat),
        .aa_valid (as_aa_tvalid),
        .aa_ready (aa_as_tready)
    );

    assign as_up_tdata = up_beat.data;
    assign as_up_tlast = up_beat.last;
    assign as_up_tuser = up_beat.user;
    assign as_aa_tdata = aa_beat.data;
    assign as_aa_tlast = aa_beat.last;
    assign as_aa_tuser = aa_beat.user;

    // threshold register
    axis_switch_cfg u_cfg (
        .axis_clk     (axis_clk),
        .axi_reset_n  (axi_reset_n),
        .cc_as_enable (cc_as_enable),
        .awvalid      (axi_awvalid),
        .awaddr       (axi_awaddr),
        .awready      (axi_awready),
        .wvalid       (axi_wvalid),
        .wdata        (axi_wdata),
        .wstrb        (axi_wstrb),
        .wready       (axi_wready),
        .arvalid      (axi_arvalid),
        .araddr       (axi_araddr),
        .arready      (axi_arready),
        .rvalid       (axi_rvalid),
        .rdata        (axi_rdata),
        .rready       (axi_rready),
        .threshold    (threshold)
    );

endmodule

// ==== logic/axis_switch_cfg.sv ====
`timescale 1ns/1ns
`include "axis_switch_consts.svh"

module axis_switch_cfg (
    input  logic                         axis_clk,
    input  logic                         axi_reset_n,
    input  logic                         cc_as_enable,
    input  logic                         awvalid,
    input  logic [`AXIS_CFG_ADDR_W-1:0]  awaddr,
    output logic                         awready,
    input  logic                         wvalid,
    input  logic [`AXIS_DATA_W-1:0]      wdata,
    input  logic [`AXIS_DATA_W/8-1:0]    wstrb,
    output logic                         wready,
    input  logic                         arvalid,
    input  logic [`AXIS_CFG_ADDR_W-1:0]  araddr,
    output logic                         arready,
    output logic                         rvalid,
    output logic [`AXIS_DATA_W-1:0]      rdata,
    input  logic                         rready,
    output axis_cfg_pkg::th_t            threshold
);

    logic                   wr_fire;
    logic                   wr_hit;
    axis_cfg_pkg::cfg_word_u wr_word;
    axis_cfg_pkg::cfg_word_u rd_word;

    ////////////////////////////////////////
    // write channel
    ////////////////////////////////////////

    // address and data taken together
    assign wr_fire = cc_as_enable && awvalid && wvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;

    // awaddr is a byte address
    assign wr_hit = (awaddr[`AXIS_CFG_ADDR_W-1:2] ==
                     (`AXIS_CFG_ADDR_W - 2)'(`AXIS_CFG_TH_OFFSET)) && wstrb[0];

    assign wr_word.raw = wdata;

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            threshold <= axis_cfg_pkg::th_t'(`AXIS_TH_RESET);
        end else if (wr_fire && wr_hit) begin
            threshold <= wr_word.f.th;
        end
    end

    ////////////////////////////////////////
    // read channel
    ////////////////////////////////////////

    // only one register, it answers at every araddr
    assign arready = !rvalid;

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            rvalid <= 1'b0;
        end else if (arvalid && arready) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_comb begin
        rd_word.raw  = '0;
        rd_word.f.th = threshold;
    end

    assign rdata = rd_word.raw;

endmodule

// ==== logic/axis_switch_consts.svh ====
`ifndef AXIS_SWITCH_CONSTS_SVH
`define AXIS_SWITCH_CONSTS_SVH

// stream beat fields
`define AXIS_DATA_W         32
`define AXIS_USER_W         2
`define AXIS_TID_W          2

// ingress buffer
`define AXIS_FIFO_DEPTH     16

// tid codes, one per upstream source
`define AXIS_TID_UP         0
`define AXIS_TID_AA         1
`define AXIS_TID_LA         2

// register map
`define AXIS_TH_RESET       6
`define AXIS_CFG_ADDR_W     15
`define AXIS_CFG_TH_OFFSET  0

`endif

// ==== logic/axis_tid_router.sv ====
`timescale 1ns/1ns
`include "axis_switch_consts.svh"

module axis_tid_router (
    axis_beat_if.sink                   head,
    output axis_stream_pkg::axis_beat_t up_beat,
    output logic                        up_valid,
    input  logic                        up_ready,
    output axis_stream_pkg::axis_beat_t aa_beat,
    output logic                        aa_valid,
    input  logic                        aa_ready
);

    logic [`AXIS_TID_W-1:0] tid;
    logic                   to_up;
    logic                   to_aa;

    assign tid   = head.beat.tid;
    assign to_up = (tid == `AXIS_TID_W'(`AXIS_TID_UP));
    assign to_aa = (tid == `AXIS_TID_W'(`AXIS_TID_AA));

    // payload goes to both, valid picks one
    assign up_beat  = head.beat;
    assign aa_beat  = head.beat;
    assign up_valid = head.valid && to_up;
    assign aa_valid = head.valid && to_aa;

    ////////////////////////////////////////
    // ready back to the FIFO
    ////////////////////////////////////////

    always_comb begin
        if (to_up) begin
            head.ready = up_ready;
        end else if (to_aa) begin
            head.ready = aa_ready;
        end else begin
            // la and unused tid, nobody listens so pop at once
            head.ready = 1'b1;
        end
    end

endmodule

// ==== logic/axis_upstream_arbiter.sv ====
`timescale 1ns/1ns
`include "axis_switch_consts.svh"

module axis_upstream_arbiter (
    input  logic                        axis_clk,
    input  logic                        axi_reset_n,
    input  axis_stream_pkg::axis_beat_t src_beat [3],
    input  logic [2:0]                  src_valid,
    output logic [2:0]                  src_ready,
    output axis_stream_pkg::axis_beat_t out_beat,
    output logic                        out_valid,
    input  logic                        out_ready
);

    localparam int NUM_SRC = 3;

    logic                      busy;
    axis_stream_pkg::src_idx_t grant;
    axis_stream_pkg::src_idx_t rr_ptr;
    axis_stream_pkg::src_idx_t pick_idx;
    logic                      pick_found;
    logic [2:0]                cand;
    logic                      pkt_done;

    ////////////////////////////////////////
    // rotated priority pick
    ////////////////////////////////////////

    // first requester at or after rr_ptr
    always_comb begin
        pick_found = 1'b0;
        pick_idx   = rr_ptr;
        cand       = '0;
        for (int i = 0; i < NUM_SRC; i++) begin
            cand = {1'b0, rr_ptr} + 3'(i);
            if (cand >= 3'(NUM_SRC)) begin
                cand = cand - 3'(NUM_SRC);
            end
            if (!pick_found && src_valid[cand[1:0]]) begin
                pick_found = 1'b1;
                pick_idx   = cand[1:0];
            end
        end
    end

    // grant held until the last beat is taken
    assign pkt_done = out_valid && out_ready && out_beat.last;

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            busy   <= 1'b0;
            grant  <= '0;
            rr_ptr <= '0;
        end else if (!busy) begin
            if (pick_found) begin
                busy   <= 1'b1;
                grant  <= pick_idx;
                rr_ptr <= (pick_idx == 2'(NUM_SRC - 1)) ? '0 : pick_idx + 2'd1;
            end
        end else if (pkt_done) begin
            // one idle cycle before the next pick
            busy <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // output mux
    ////////////////////////////////////////

    always_comb begin
        out_beat  = src_beat[grant];
        out_valid = 1'b0;
        src_ready = '0;
        if (busy) begin
            out_valid        = src_valid[grant];
            src_ready[grant] = out_ready;
        end
        // tag with the granted source
        case (grant)
            2'd1:    out_beat.tid = `AXIS_TID_W'(`AXIS_TID_AA);
            2'd2:    out_beat.tid = `AXIS_TID_W'(`AXIS_TID_LA);
            default: out_beat.tid = `AXIS_TID_W'(`AXIS_TID_UP);
        endcase
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f src.f --top-module axis_switch_tb -o sim
./obj_dir/sim > sim.log 2>&1 || true
cat sim.log

if grep -q "=== PASS ===" sim.log; then
    exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

// ==== src.f ====
+incdir+logic
logic/axis_stream_pkg.sv
logic/axis_cfg_pkg.sv
logic/axis_beat_if.sv
logic/axis_upstream_arbiter.sv
logic/axis_ingress_fifo.sv
logic/axis_tid_router.sv
logic/axis_switch_cfg.sv
logic/axis_switch.sv
testbench/axis_switch_tb.sv

// ==== testbench/axis_switch_tb.sv ====
`timescale 1ns/1ns
`include "axis_switch_consts.svh"

module axis_switch_tb;

    logic        axis_clk;
    logic        axi_reset_n;
    logic        cc_as_enable;
    logic        axi_awvalid;
    logic [`AXIS_CFG_ADDR_W-1:0] axi_awaddr;
    logic        axi_wvalid;
    logic [31:0] axi_wdata;
    logic [3:0]  axi_wstrb;
    logic        axi_arvalid;
    logic [`AXIS_CFG_ADDR_W-1:0] axi_araddr;
    logic        axi_rready;
    wire         axi_awready;
    wire         axi_wready;
    wire         axi_arready;
    wire         axi_rvalid;
    wire  [31:0] axi_rdata;

    // upstream sources indexed by tid
    logic [31:0] src_data [3];
    logic        src_last [3];
    logic [1:0]  src_user [3];
    logic [2:0]  src_valid;
    wire  [2:0]  src_ready;
    wire  [31:0] as_is_tdata;
    wire         as_is_tlast;
    wire  [1:0]  as_is_tuser;
    wire  [1:0]  as_is_tid;
    wire         as_is_tvalid;
    logic        is_as_tready;

    // serdes side and destinations
    logic [31:0] is_as_tdata;
    logic        is_as_tlast;
    logic [1:0]  is_as_tuser;
    logic [1:0]  is_as_tid;
    logic        is_as_tvalid;
    wire         as_is_tready;
    wire  [31:0] as_up_tdata;
    wire         as_up_tlast;
    wire  [1:0]  as_up_tuser;
    wire         as_up_tvalid;
    logic        up_as_tready;
    wire  [31:0] as_aa_tdata;
    wire         as_aa_tlast;
    wire  [1:0]  as_aa_tuser;
    wire         as_aa_tvalid;
    logic        aa_as_tready;

    integer      seed = 32'hacc0_55c7;
    integer      errors = 0;
    integer      checks = 0;
    logic        up_run = 0;
    logic        ds_run = 0;
    logic        th_phase = 0;
    logic [1:0]  dst_mode = 2;
    logic [3:0]  th_model = 6;
    int          src_rem [3] = '{0, 0, 0};

    // expected beats as {user, last, data}
    logic [34:0] src_q0 [$];
    logic [34:0] src_q1 [$];
    logic [34:0] src_q2 [$];
    logic [34:0] up_q [$];
    logic [34:0] aa_q [$];

    // arbiter and FIFO model state kept by the monitor
    logic        m_busy = 0;
    logic [1:0]  m_grant = 0;
    logic [1:0]  m_ptr = 0;
    int          m_occ = 0;
    logic        m_rdy = 1;
    logic        src_seen [3] = '{0, 0, 0};

    axis_switch UUT (
        .axis_clk(axis_clk), .axi_reset_n(axi_reset_n), .cc_as_enable(cc_as_enable),
        .axi_awvalid(axi_awvalid), .axi_awaddr(axi_awaddr), .axi_awready(axi_awready),
        .axi_wvalid(axi_wvalid), .axi_wdata(axi_wdata), .axi_wstrb(axi_wstrb),
        .axi_wready(axi_wready), .axi_arvalid(axi_arvalid), .axi_araddr(axi_araddr),
        .axi_arready(axi_arready), .axi_rvalid(axi_rvalid), .axi_rdata(axi_rdata),
        .axi_rready(axi_rready),
        .up_as_tdata(src_data[0]), .up_as_tlast(src_last[0]), .up_as_tuser(src_user[0]),
        .up_as_tvalid(src_valid[0]), .as_up_tready(src_ready[0]),
        .aa_as_tdata(src_data[1]), .aa_as_tlast(src_last[1]), .aa_as_tuser(src_user[1]),
        .aa_as_tvalid(src_valid[1]), .as_aa_tready(src_ready[1]),
        .la_as_tdata(src_data[2]), .la_as_tlast(src_last[2]), .la_as_tuser(src_user[2]),
        .la_as_tvalid(src_valid[2]), .as_la_tready(src_ready[2]),
        .as_is_tdata(as_is_tdata), .as_is_tlast(as_is_tlast), .as_is_tuser(as_is_tuser),
        .as_is_tid(as_is_tid), .as_is_tvalid(as_is_tvalid), .is_as_tready(is_as_tready),
        .is_as_tdata(is_as_tdata), .is_as_tlast(is_as_tlast), .is_as_tuser(is_as_tuser),
        .is_as_tid(is_as_tid), .is_as_tvalid(is_as_tvalid), .as_is_tready(as_is_tready),
        .as_up_tdata(as_up_tdata), .as_up_tlast(as_up_tlast), .as_up_tuser(as_up_tuser),
        .as_up_tvalid(as_up_tvalid), .up_as_tready(up_as_tready),
        .as_aa_tdata(as_aa_tdata), .as_aa_tlast(as_aa_tlast), .as_aa_tuser(as_aa_tuser),
        .as_aa_tvalid(as_aa_tvalid), .aa_as_tready(aa_as_tready)
    );

    initial begin
        axis_clk = 0;
        forever #50 axis_clk = ~axis_clk;
    end

    ////////////////////////////////////////
    // checking helpers
    ////////////////////////////////////////

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp,
                            input string what);
        checks++;
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic give_up(input string what);
        $display("timeout: %s did not happen in time", what);
        $display("errors: %0d mismatches, 1 timeout, %0d checks", errors, checks);
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic pop_src(input logic [1:0] tid, output logic [34:0] b, output logic ok);
        ok = 1;
        b  = '0;
        if (tid == 0 && src_q0.size() > 0) b = src_q0.pop_front();
        else if (tid == 1 && src_q1.size() > 0) b = src_q1.pop_front();
        else if (tid == 2 && src_q2.size() > 0) b = src_q2.pop_front();
        else ok = 0;
    endtask

    ////////////////////////////////////////
    // random stimulus
    ////////////////////////////////////////

    // upstream sources hold a beat until it is taken
    always @(posedge axis_clk) begin
        if (axi_reset_n) begin
            for (int s = 0; s < 3; s++) begin
                if (!src_valid[s] || src_ready[s]) begin
                    if ((up_run || src_rem[s] != 0) && $unsigned($random(seed)) % 4 != 0) begin
                        if (src_rem[s] == 0)
                            src_rem[s] = 1 + $unsigned($random(seed)) % 4;
                        src_rem[s]   = src_rem[s] - 1;
                        src_data[s] <= $random(seed);
                        src_user[s] <= $random(seed);
                        src_last[s] <= (src_rem[s] == 0);
                        src_valid[s] <= 1'b1;
                    end else begin
                        src_valid[s] <= 1'b0;
                    end
                end
            end
            is_as_tready <= ($unsigned($random(seed)) % 3 != 0);
        end
    end

    // serdes beats with tid 2 and 3 only outside the threshold phase
    always @(posedge axis_clk) begin
        logic [34:0] b;
        logic [1:0]  t;
        if (axi_reset_n) begin
            if (!is_as_tvalid || as_is_tready) begin
                if (ds_run && $unsigned($random(seed)) % 3 != 0) begin
                    t = th_phase ? 2'($unsigned($random(seed)) % 2) : 2'($random(seed));
                    b = {2'($random(seed)), 1'($random(seed)), 32'($random(seed))};
                    if (t == 0) up_q.push_back(b);
                    if (t == 1) aa_q.push_back(b);
                    {is_as_tuser, is_as_tlast, is_as_tdata} <= b;
                    is_as_tid    <= t;
                    is_as_tvalid <= 1'b1;
                end else begin
                    is_as_tvalid <= 1'b0;
                end
            end
            up_as_tready <= (dst_mode == 2) || (dst_mode == 1 && $random(seed) % 2 != 0);
            aa_as_tready <= (dst_mode == 2) || (dst_mode == 1 && $random(seed) % 2 != 0);
        end
    end

    ////////////////////////////////////////
    // monitor and reference model
    ////////////////////////////////////////

    always @(posedge axis_clk) begin
        logic [34:0] b;
        logic        ok;
        logic        found;
        logic [1:0]  c;
        logic        up_hs;
        logic        aa_hs;
        if (axi_reset_n) begin
            // each upstream beat queued once in the cycle it first shows
            for (int s = 0; s < 3; s++) begin
                if (src_valid[s] && src_seen[s] == 0) begin
                    b = {src_user[s], src_last[s], src_data[s]};
                    if (s == 0) src_q0.push_back(b);
                    else if (s == 1) src_q1.push_back(b);
                    else src_q2.push_back(b);
                end
            end
            check_eq(as_is_tvalid, m_busy && src_valid[m_grant], "as_is_tvalid");
            if (as_is_tvalid && is_as_tready) begin
                check_eq(as_is_tid, m_grant, "upstream tid");
                pop_src(as_is_tid, b, ok);
                check_eq(ok, 1, "upstream beat expected");
                check_eq({as_is_tuser, as_is_tlast, as_is_tdata}, b, "upstream beat");
            end
            for (int s = 0; s < 3; s++) begin
                src_seen[s] = src_valid[s] && !src_ready[s];
            end
            // arbiter state for the next cycle
            if (!m_busy) begin
                found = 0;
                for (int i = 0; i < 3; i++) begin
                    c = 2'((m_ptr + i) % 3);
                    if (!found && src_valid[c]) begin
                        found   = 1;
                        m_busy  = 1;
                        m_grant = c;
                    end
                end
                if (found) m_ptr = (m_grant == 2) ? 2'd0 : m_grant + 2'd1;
            end else if (as_is_tvalid && is_as_tready && as_is_tlast) begin
                m_busy = 0;
            end

            up_hs = as_up_tvalid && up_as_tready;
            aa_hs = as_aa_tvalid && aa_as_tready;
            if (up_hs) begin
                check_eq(up_q.size() > 0, 1, "user project beat expected");
                if (up_q.size() > 0)
                    check_eq({as_up_tuser, as_up_tlast, as_up_tdata}, up_q.pop_front(),
                             "user project beat");
            end
            if (aa_hs) begin
                check_eq(aa_q.size() > 0, 1, "bridge beat expected");
                if (aa_q.size() > 0)
                    check_eq({as_aa_tuser, as_aa_tlast, as_aa_tdata}, aa_q.pop_front(),
                             "bridge beat");
            end
            if (th_phase) begin
                check_eq(as_is_tready, m_rdy, "as_is_tready vs threshold");
                m_occ = m_occ + (is_as_tvalid && as_is_tready) - up_hs - aa_hs;
                m_rdy = (m_occ <= th_model);
                check_eq(m_occ <= `AXIS_FIFO_DEPTH, 1, "FIFO occupancy within depth");
            end else begin
                m_occ = 0;
                m_rdy = 1;
            end
        end
    end

    ////////////////////////////////////////
    // sequences
    ////////////////////////////////////////

    task automatic drain_all();
        int n;
        n = 0;
        while (src_q0.size() + src_q1.size() + src_q2.size() != 0 || src_valid != 0) begin
            @(posedge axis_clk);
            n++;
            if (n > 3000) give_up("upstream drain");
        end
        n = 0;
        while (up_q.size() + aa_q.size() != 0 || is_as_tvalid) begin
            @(posedge axis_clk);
            n++;
            if (n > 3000) give_up("downstream drain");
        end
        // dropped tids leave the FIFO one per cycle
        repeat (20) @(posedge axis_clk);
    endtask

    task automatic cfg_write(input logic [14:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic en);
        int n;
        @(posedge axis_clk);
        cc_as_enable <= en;
        axi_awvalid  <= 1;
        axi_wvalid   <= 1;
        axi_awaddr   <= addr;
        axi_wdata    <= data;
        axi_wstrb    <= strb;
        n = 0;
        do begin
            @(posedge axis_clk);
            n++;
            if (!en) check_eq(axi_awready, 0, "awready while disabled");
            if (!en) check_eq(axi_wready, 0, "wready while disabled");
            if (en && n > 20) give_up("awready");
        end while (en ? !(axi_awready && axi_wready) : n < 3);
        axi_awvalid  <= 0;
        axi_wvalid   <= 0;
        cc_as_enable <= 1;
    endtask

    task automatic cfg_read_check(input logic [31:0] exp);
        int n;
        @(posedge axis_clk);
        axi_arvalid <= 1;
        axi_araddr  <= $random(seed);
        n = 0;
        do begin
            @(posedge axis_clk);
            n++;
            if (n > 20) give_up("arready");
        end while (!axi_arready);
        axi_arvalid <= 0;
        axi_rready  <= 1;
        n = 0;
        do begin
            @(posedge axis_clk);
            n++;
            if (n > 20) give_up("rvalid");
        end while (!axi_rvalid);
        check_eq(axi_rdata, exp, "threshold read");
        axi_rready <= 0;
    endtask

    task automatic threshold_phase();
        @(posedge axis_clk);
        dst_mode <= 0;
        th_phase <= 1;
        ds_run   <= 1;
        repeat (40) @(posedge axis_clk);
        dst_mode <= 1;
        repeat (150) @(posedge axis_clk);
        ds_run <= 0;
        drain_all();
        th_phase <= 0;
        dst_mode <= 2;
    endtask

    initial begin
        axi_reset_n  <= 0;
        cc_as_enable <= 1;
        axi_awvalid  <= 0;
        axi_awaddr   <= 0;
        axi_wvalid   <= 0;
        axi_wdata    <= 0;
        axi_wstrb    <= 0;
        axi_arvalid  <= 0;
        axi_araddr   <= 0;
        axi_rready   <= 0;
        src_data     <= '{0, 0, 0};
        src_last     <= '{0, 0, 0};
        src_user     <= '{0, 0, 0};
        src_valid    <= 0;
        is_as_tready <= 0;
        is_as_tdata  <= 0;
        is_as_tlast  <= 0;
        is_as_tuser  <= 0;
        is_as_tid    <= 0;
        is_as_tvalid <= 0;
        up_as_tready <= 0;
        aa_as_tready <= 0;
        repeat (4) @(posedge axis_clk);
        axi_reset_n <= 1;
        @(posedge axis_clk);
        check_eq({as_is_tvalid, as_up_tvalid, as_aa_tvalid, axi_rvalid}, 0, "valids after reset");
        check_eq(as_is_tready, 1, "as_is_tready after reset");
        cfg_read_check(6);

        // mixed traffic both ways
        up_run   <= 1;
        ds_run   <= 1;
        dst_mode <= 1;
        repeat (800) @(posedge axis_clk);
        up_run <= 0;
        ds_run <= 0;
        drain_all();

        threshold_phase();

        cfg_write(0, 32'h0000_0009, 4'h1, 1);
        cfg_read_check(9);
        cfg_write(4, 32'h0000_0003, 4'h1, 1);
        cfg_write(0, 32'h0000_0003, 4'he, 1);
        cfg_write(0, 32'h0000_0003, 4'h1, 0);
        cfg_read_check(9);
        th_model = 9;
        threshold_phase();

        repeat (5) @(posedge axis_clk);
        $display("errors: %0d mismatches, 0 timeouts, %0d checks", errors, checks);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // whole run bound
    initial begin
        #5_000_000;
        give_up("end of test");
    end

endmodule
